// File: hw/soc_pkg.sv
`default_nettype none

package soc_pkg;

        // ------------------------------
        // Widths
        // ------------------------------
        localparam int WORD_W = 32;
        localparam int ADDR_W = 8;
        localparam int LED_W  = 8;
        localparam int BYTE_W = 8;
        localparam int IRQ_N  = 2;     // Timer and uart done

        // Serial bit period in clk cycles
        localparam int BAUD_DIV   = 16;
        localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
        localparam int BIT_IDX_W  = $clog2(BYTE_W);

        // Control and status bit positions
        localparam int CTRL_EN_BIT     = 0;
        localparam int STATUS_BUSY_BIT = 0;

        typedef logic [WORD_W-1:0] word_t;
        typedef logic [ADDR_W-1:0] addr_t;
        typedef logic [LED_W-1:0]  led_t;

        // ------------------------------
        // Register map
        // ------------------------------
        typedef enum addr_t {
                REG_LED        = 8'h00,
                REG_TIMER_LOAD = 8'h04,
                REG_TIMER_CTRL = 8'h08,
                REG_UART_DATA  = 8'h0C,
                REG_STATUS     = 8'h10,
                REG_IRQ_PEND   = 8'h14
        } reg_addr_e;

        typedef enum logic [0:0] {
                IRQ_TIMER = 1'b0,
                IRQ_UART  = 1'b1
        } irq_bit_e;

        typedef struct packed {
                logic  wr;
                logic  rd;
                addr_t addr;
                word_t wdata;
        } bus_req_t;

        typedef struct packed {
                logic  enable;
                word_t load;
        } timer_cfg_t;

        typedef struct packed {
                logic              start;  // One cycle pulse
                logic [BYTE_W-1:0] data;
        } uart_req_t;

        typedef enum logic [1:0] {
                IDLE,
                START,
                DATA,
                STOP
        } uart_state_e;

endpackage

`default_nettype wire

// File: hw/soc_timer.sv
`timescale 1ns/1ns
`default_nettype none

module soc_timer import soc_pkg::*; (
        input  logic       clk,
        input  logic       RSTn,
        input  timer_cfg_t cfg,
        output logic       expire
);

        // ------------------------------
        // Reloading down counter
        // ------------------------------
        word_t count_q;
        logic  at_zero;

        assign at_zero = (count_q == '0);

        // Expiries are load + 1 cycles apart
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        count_q <= '0;
                        expire  <= 1'b0;
                end else if (!cfg.enable) begin
                        count_q <= cfg.load;       // Stopped and ready to run
                        expire  <= 1'b0;
                end else if (at_zero) begin
                        count_q <= cfg.load;       // Reload on expiry
                        expire  <= 1'b1;
                end else begin
                        count_q <= count_q - 1'b1;
                        expire  <= 1'b0;
                end
        end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx import soc_pkg::*; (
        input  logic      clk,
        input  logic      RSTn,
        input  uart_req_t req,
        output logic      txd,
        output logic      busy,
        output logic      done
);

        uart_state_e           state_q;
        logic [BAUD_CNT_W-1:0] baud_q;
        logic [BIT_IDX_W-1:0]  bit_q;
        logic [BYTE_W-1:0]     data_q;
        logic                  baud_last;
        logic                  accept;

        assign baud_last = (baud_q == BAUD_CNT_W'(BAUD_DIV - 1));
        assign accept    = (state_q == IDLE) && req.start;  // Start while busy is dropped
        assign busy      = (state_q != IDLE);

        // ------------------------------
        // Baud timing
        // ------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        baud_q <= '0;
                end else if (state_q == IDLE || baud_last) begin
                        baud_q <= '0;
                end else begin
                        baud_q <= baud_q + 1'b1;
                end
        end

        // Byte captured on accept
        always_ff @(posedge clk) begin
                if (accept)
                        data_q <= req.data;
        end

        // ------------------------------
        // Frame FSM
        // ------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        state_q <= IDLE;
                        bit_q   <= '0;
                        done    <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state_q)
                                IDLE: begin
                                        if (accept)
                                                state_q <= START;
                                end
                                START: begin
                                        if (baud_last) begin
                                                state_q <= DATA;
                                                bit_q   <= '0;
                                        end
                                end
                                DATA: begin
                                        if (baud_last) begin
                                                if (bit_q == BIT_IDX_W'(BYTE_W - 1))
                                                        state_q <= STOP;
                                                else
                                                        bit_q <= bit_q + 1'b1;
                                        end
                                end
                                STOP: begin
                                        if (baud_last) begin
                                                state_q <= IDLE;
                                                done    <= 1'b1;  // Frame finished
                                        end
                                end
                                default: state_q <= IDLE;
                        endcase
                end
        end

        // Serial line, LSB first
        always_comb begin
                case (state_q)
                        START:   txd = 1'b0;
                        DATA:    txd = data_q[bit_q];
                        default: txd = 1'b1;  // Idle and stop are high
                endcase
        end

endmodule

`default_nettype wire

// File: hw/soc_regs.sv
`timescale 1ns/1ns
`default_nettype none

module soc_regs import soc_pkg::*; (
        input  logic       clk,
        input  logic       RSTn,
        input  bus_req_t   bus,
        output word_t      rdata,
        output led_t       led,
        output timer_cfg_t timer_cfg,
        input  logic       timer_expire,
        output uart_req_t  uart_req,
        input  logic       uart_busy,
        input  logic       uart_done,
        output logic       irq
);

        // ------------------------------
        // Address decode
        // ------------------------------
        logic             wr_led;
        logic             wr_load;
        logic             wr_ctrl;
        logic             wr_uart;
        logic             wr_pend;
        logic [IRQ_N-1:0] pend_q;
        logic [IRQ_N-1:0] pend_set;
        logic [IRQ_N-1:0] pend_clr;
        word_t            rd_mux;

        assign wr_led  = bus.wr && (bus.addr == REG_LED);
        assign wr_load = bus.wr && (bus.addr == REG_TIMER_LOAD);
        assign wr_ctrl = bus.wr && (bus.addr == REG_TIMER_CTRL);
        assign wr_uart = bus.wr && (bus.addr == REG_UART_DATA);
        assign wr_pend = bus.wr && (bus.addr == REG_IRQ_PEND);

        // LED output register
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        led <= '0;
                end else if (wr_led) begin
                        led <= bus.wdata[LED_W-1:0];
                end
        end

        // Timer load and enable, held as levels
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        timer_cfg <= '0;
                end else begin
                        if (wr_load)
                                timer_cfg.load <= bus.wdata;
                        if (wr_ctrl)
                                timer_cfg.enable <= bus.wdata[CTRL_EN_BIT];
                end
        end

        // Start pulse follows the data write by one edge
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        uart_req <= '0;
                end else begin
                        uart_req.start <= wr_uart;
                        if (wr_uart)
                                uart_req.data <= bus.wdata[BYTE_W-1:0];
                end
        end

        // ------------------------------
        // Interrupt pending
        // ------------------------------
        assign pend_set[IRQ_TIMER] = timer_expire;
        assign pend_set[IRQ_UART]  = uart_done;
        assign pend_clr = wr_pend ? bus.wdata[IRQ_N-1:0] : '0;

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        pend_q <= '0;
                        irq    <= 1'b0;
                end else begin
                        pend_q <= (pend_q & ~pend_clr) | pend_set;  // Set wins
                        irq    <= |pend_q;
                end
        end

        // ------------------------------
        // Read path
        // ------------------------------
        always_comb begin
                rd_mux = '0;  // Unmapped reads as zero
                case (bus.addr)
                        REG_LED:        rd_mux[LED_W-1:0]  = led;
                        REG_TIMER_LOAD: rd_mux             = timer_cfg.load;
                        REG_TIMER_CTRL: rd_mux[CTRL_EN_BIT] = timer_cfg.enable;
                        REG_UART_DATA:  rd_mux[BYTE_W-1:0] = uart_req.data;
                        REG_STATUS:     rd_mux[STATUS_BUSY_BIT] = uart_busy;
                        REG_IRQ_PEND:   rd_mux[IRQ_N-1:0]  = pend_q;
                        default:        rd_mux             = '0;
                endcase
        end

        // Held until the next read strobe
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        rdata <= '0;
                end else if (bus.rd) begin
                        rdata <= rd_mux;
                end
        end

endmodule

`default_nettype wire

// File: hw/periph_soc.sv
`timescale 1ns/1ns
`default_nettype none

module periph_soc import soc_pkg::*; (
        input  logic     clk,
        input  logic     RSTn,
        input  bus_req_t bus,
        output word_t    rdata,
        output led_t     led,
        output logic     txd,
        output logic     irq
);

        // ------------------------------
        // Internal links
        // ------------------------------
        timer_cfg_t timer_cfg;
        logic       timer_expire;
        uart_req_t  uart_req;
        logic       uart_busy;
        logic       uart_done;

        // Bus decode and registers
        soc_regs regs_i (
                .clk          (clk),
                .RSTn         (RSTn),
                .bus          (bus),
                .rdata        (rdata),
                .led          (led),
                .timer_cfg    (timer_cfg),
                .timer_expire (timer_expire),
                .uart_req     (uart_req),
                .uart_busy    (uart_busy),
                .uart_done    (uart_done),
                .irq          (irq)
        );

        soc_timer timer_i (
                .clk    (clk),
                .RSTn   (RSTn),
                .cfg    (timer_cfg),
                .expire (timer_expire)
        );

        // Serial transmitter
        uart_tx uart_i (
                .clk  (clk),
                .RSTn (RSTn),
                .req  (uart_req),
                .txd  (txd),
                .busy (uart_busy),
                .done (uart_done)
        );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
        output logic clk,
        output logic RSTn
);

        // 10 ns period
        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        initial begin
                RSTn = 1'b0;
                repeat (10) @(posedge clk);
                #1 RSTn = 1'b1;  // Released just after the tenth edge
        end

endmodule

`default_nettype wire

// File: bench/periph_soc_properties.sv
`timescale 1ns/1ns
`default_nettype none

module periph_soc_properties import soc_pkg::*; (
        input logic     clk,
        input logic     RSTn,
        input bus_req_t bus,
        input logic     txd,
        input logic     uart_busy,
        input logic     timer_expire,
        input logic     irq
);

        logic pend_wr;

        assign pend_wr = bus.wr && (bus.addr == REG_IRQ_PEND);

        // Line rests high between frames
        idle_txd_high: assert property (@(posedge clk) disable iff (!RSTn)
                !uart_busy |-> txd)
                else $error("txd low while the transmitter is idle");

        expire_single: assert property (@(posedge clk) disable iff (!RSTn)
                timer_expire |=> !timer_expire)
                else $error("timer expire high for two cycles in a row");

        // A clear reaches irq two edges after the write
        irq_held: assert property (@(posedge clk) disable iff (!RSTn)
                irq && !pend_wr && !$past(pend_wr) |=> irq)
                else $error("irq dropped without a write to the pending register");

endmodule

bind periph_soc periph_soc_properties props_i (
        .clk          (clk),
        .RSTn         (RSTn),
        .bus          (bus),
        .txd          (txd),
        .uart_busy    (uart_busy),
        .timer_expire (timer_expire),
        .irq          (irq)
);

`default_nettype wire

// File: bench/tb_periph_soc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_periph_soc import soc_pkg::*; ();

        logic     clk;
        logic     RSTn;
        bus_req_t bus;
        word_t    rdata;
        led_t     led;
        logic     txd;
        logic     irq;
        int       errors = 0;
        int       cycle_cnt = 0;

        tb_clock clock_i (.clk(clk), .RSTn(RSTn));

        periph_soc dut_i (
                .clk   (clk),
                .RSTn  (RSTn),
                .bus   (bus),
                .rdata (rdata),
                .led   (led),
                .txd   (txd),
                .irq   (irq)
        );

        always @(posedge clk)
                cycle_cnt <= cycle_cnt + 1;  // Time base for timing checks

        // ------------------------------
        // Bus access
        // ------------------------------
        task automatic bus_write(input addr_t addr, input word_t data);
                @(posedge clk);
                #1;
                bus.wr    = 1'b1;
                bus.addr  = addr;
                bus.wdata = data;
                @(posedge clk);
                #1;
                bus.wr = 1'b0;
        endtask

        task automatic bus_read(input addr_t addr, output word_t data);
                @(posedge clk);
                #1;
                bus.rd   = 1'b1;
                bus.addr = addr;
                @(posedge clk);
                #1;
                bus.rd = 1'b0;
                data   = rdata;  // Registered at the strobe edge
        endtask

        task automatic check_word(input string name, input word_t got, input word_t exp);
                if (got !== exp) begin
                        errors++;
                        $display("FAIL %s: got %h, expected %h", name, got, exp);
                end
        endtask

        task automatic check_led(input string name, input led_t got, input led_t exp);
                if (got !== exp) begin
                        errors++;
                        $display("FAIL %s: got %h, expected %h", name, got, exp);
                end
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                if (got !== exp) begin
                        errors++;
                        $display("FAIL %s: got %h, expected %h", name, got, exp);
                end
        endtask

        // ------------------------------
        // Bounded waits
        // ------------------------------
        task automatic wait_irq(input logic level, input int limit);
                int n;
                n = 0;
                while (irq !== level && n < limit) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                if (irq !== level) begin
                        errors++;
                        $display("Timed out waiting for irq to become %0d", level);
                end
        endtask

        task automatic wait_start(output int t0);
                int n;
                n = 0;
                while (txd !== 1'b0 && n < 4 * BAUD_DIV) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                t0 = cycle_cnt;
                if (txd !== 1'b0) begin
                        errors++;
                        $display("No start bit appeared on txd in time");
                end
        endtask

        task automatic wait_cycle(input int target);
                int n;
                n = 0;
                while (cycle_cnt < target && n < 20 * BAUD_DIV) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                if (cycle_cnt != target) begin
                        errors++;
                        $display("Missed the txd sample point at cycle %0d", target);
                end
        endtask

        task automatic wait_uart_idle();
                word_t status;
                int    n;
                n = 0;
                bus_read(REG_STATUS, status);
                while (status[STATUS_BUSY_BIT] !== 1'b0 && n < 200) begin
                        bus_read(REG_STATUS, status);
                        n++;
                end
                if (status[STATUS_BUSY_BIT] !== 1'b0) begin
                        errors++;
                        $display("Transmitter stayed busy far too long");
                end
        endtask

        // Start, data LSB first, stop, each sampled mid bit
        task automatic check_frame(input logic [BYTE_W-1:0] data, input int t0);
                logic exp_bit;
                for (int k = 0; k < BYTE_W + 2; k++) begin
                        if (k == 0)
                                exp_bit = 1'b0;
                        else if (k == BYTE_W + 1)
                                exp_bit = 1'b1;
                        else
                                exp_bit = data[k-1];
                        wait_cycle(t0 + BAUD_DIV / 2 + k * BAUD_DIV);
                        check_bit("txd", txd, exp_bit);
                end
        endtask

        // ------------------------------
        // Directed tests
        // ------------------------------
        task automatic test_reset();
                word_t data;
                check_led("led", led, '0);
                check_bit("txd", txd, 1'b1);
                check_bit("irq", irq, 1'b0);
                bus_read(REG_STATUS, data);
                check_word("status", data, '0);
                bus_read(REG_IRQ_PEND, data);
                check_word("irq_pend", data, '0);
        endtask

        task automatic test_led();
                word_t value;
                word_t data;
                value = $urandom;
                bus_write(REG_LED, value);
                check_led("led", led, value[LED_W-1:0]);
                bus_read(REG_LED, data);
                check_word("rdata", data, word_t'(value[LED_W-1:0]));
                bus_read(8'h3C, data);  // Unmapped
                check_word("rdata", data, '0);
                bus_write(8'h3C, ~value);
                check_led("led", led, value[LED_W-1:0]);
        endtask

        task automatic test_timer();
                word_t load;
                int    t_first;
                load = 3 + ($urandom % 18);
                bus_write(REG_TIMER_LOAD, load);
                bus_write(REG_TIMER_CTRL, 32'h1);
                wait_irq(1'b1, 200);
                t_first = cycle_cnt;
                bus_write(REG_IRQ_PEND, 1 << IRQ_TIMER);
                wait_irq(1'b0, 10);
                wait_irq(1'b1, 200);
                check_word("timer period", word_t'(cycle_cnt - t_first), load + 1);
                bus_write(REG_TIMER_CTRL, 32'h0);
                bus_write(REG_IRQ_PEND, 1 << IRQ_TIMER);
                wait_irq(1'b0, 10);
                check_bit("irq", irq, 1'b0);
        endtask

        task automatic test_uart_frame();
                logic [BYTE_W-1:0] data_byte;
                word_t             data;
                int                t0;
                data_byte = BYTE_W'($urandom);
                bus_write(REG_UART_DATA, word_t'(data_byte));
                wait_start(t0);
                check_frame(data_byte, t0);
                wait_uart_idle();
                bus_read(REG_IRQ_PEND, data);
                check_word("irq_pend", data, 1 << IRQ_UART);
                check_bit("irq", irq, 1'b1);
                bus_write(REG_IRQ_PEND, 1 << IRQ_UART);
                wait_irq(1'b0, 10);
                check_bit("irq", irq, 1'b0);
        endtask

        task automatic test_uart_busy();
                logic [BYTE_W-1:0] first;
                word_t             data;
                logic              line_high;
                int                t0;
                first = BYTE_W'($urandom);
                bus_write(REG_UART_DATA, word_t'(first));
                wait_start(t0);
                bus_read(REG_STATUS, data);
                check_word("status", data, 1 << STATUS_BUSY_BIT);
                bus_write(REG_UART_DATA, word_t'(~first));  // Dropped while busy
                check_frame(first, t0);
                // No second frame may follow the first one
                line_high = 1'b1;
                repeat (3 * BAUD_DIV) begin
                        @(posedge clk);
                        #1;
                        line_high = line_high & txd;
                end
                check_bit("txd", line_high, 1'b1);
                bus_read(REG_STATUS, data);
                check_word("status", data, '0);
        endtask

        initial begin
                int n;
                bus = '0;
                void'($urandom(32'hfd1c));
                n   = 0;
                while (RSTn !== 1'b1 && n < 50) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                if (RSTn !== 1'b1) begin
                        errors++;
                        $display("Reset was never released");
                end
                test_reset();
                test_led();
                test_timer();
                test_uart_frame();
                test_uart_busy();
                $display("Errors: %0d", errors);
                if (errors == 0)
                        $display("Simulation completed successfully");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule

`default_nettype wire

// File: build.f
hw/soc_pkg.sv
hw/soc_timer.sv
hw/uart_tx.sv
hw/soc_regs.sv
hw/periph_soc.sv
bench/tb_clock.sv
bench/periph_soc_properties.sv
bench/tb_periph_soc.sv
